//--- include/mips_alu_defs.svh
`ifndef MIPS_ALU_DEFS_SVH
`define MIPS_ALU_DEFS_SVH

// datapath widths
`define MIPS_ALU_DATA_W 32
`define MIPS_ALU_ADR_W 3
`define MIPS_ALU_OP_W 5
`define MIPS_ALU_SHAMT_W 5

// codes 0..25 are legal, the rest flag illegal_op
`define MIPS_ALU_NUM_OPS 26

// one quotient bit per divide step
`define MIPS_ALU_DIV_STEPS 32

// op sits in 4:0 and shamt in 12:8 of the control word
`define MIPS_ALU_CTRL_SHAMT_LSB 8

// status word bit positions
`define MIPS_ALU_STAT_BUSY 0
`define MIPS_ALU_STAT_DIV_ZERO 1
`define MIPS_ALU_STAT_ILLEGAL 2

`endif

//--- design/mips_alu_pkg.sv
`include "mips_alu_defs.svh"

package mips_alu_pkg;

    // ALU control codes 0 to 25
    typedef enum logic [`MIPS_ALU_OP_W-1:0] {
        op_add     = 5'd0,
        op_sub     = 5'd1,
        op_mult    = 5'd2,
        op_multu   = 5'd3,
        op_div     = 5'd4,
        op_divu    = 5'd5,
        op_and     = 5'd6,
        op_or      = 5'd7,
        op_xor     = 5'd8,
        op_sll     = 5'd9,
        op_sllv    = 5'd10,
        op_srl     = 5'd11,
        op_srlv    = 5'd12,
        op_sra     = 5'd13,
        op_srav    = 5'd14,
        op_eq      = 5'd15,
        op_gez     = 5'd16,
        op_gtz     = 5'd17,
        op_lez     = 5'd18,
        op_ltz     = 5'd19,
        op_slt     = 5'd20,
        op_sltu    = 5'd21,
        op_ne      = 5'd22,
        op_pass_rs = 5'd23,
        op_jump    = 5'd24,
        op_lui     = 5'd25
    } alu_op_t;

    // word addresses on the bus
    typedef enum logic [`MIPS_ALU_ADR_W-1:0] {
        reg_rs     = 3'd0,
        reg_rt     = 3'd1,
        reg_ctrl   = 3'd2,
        reg_result = 3'd3,
        reg_lo     = 3'd4,
        reg_hi     = 3'd5,
        reg_status = 3'd6
    } reg_addr_t;

endpackage

//--- design/mips_alu.sv
`timescale 1ns/1ps
`include "mips_alu_defs.svh"

module mips_alu (
    input  logic [`MIPS_ALU_DATA_W-1:0]  rs,
    input  logic [`MIPS_ALU_DATA_W-1:0]  rt,
    input  logic [`MIPS_ALU_SHAMT_W-1:0] shamt,
    input  mips_alu_pkg::alu_op_t        op,
    output logic [`MIPS_ALU_DATA_W-1:0]  result
);

    logic [`MIPS_ALU_SHAMT_W-1:0] var_sh;  // shift amount for the v forms
    logic                         rs_neg;
    logic                         rs_zero;
    logic                         lt_s;
    logic                         lt_u;

    assign var_sh  = rs[`MIPS_ALU_SHAMT_W-1:0];
    assign rs_neg  = rs[`MIPS_ALU_DATA_W-1];
    assign rs_zero = (rs == '0);
    assign lt_s    = ($signed(rs) < $signed(rt));
    assign lt_u    = (rs < rt);

    // compare ops only touch bit 0, rest stays 0
    always_comb begin
        result = '0;
        case (op)
            mips_alu_pkg::op_add: begin
                result = rs + rt;  // no overflow trap
            end
            mips_alu_pkg::op_sub: begin
                result = rs - rt;
            end
            mips_alu_pkg::op_and: begin
                result = rs & rt;
            end
            mips_alu_pkg::op_or: begin
                result = rs | rt;
            end
            mips_alu_pkg::op_xor: begin
                result = rs ^ rt;
            end
            mips_alu_pkg::op_sll: begin
                result = rt << shamt;
            end
            mips_alu_pkg::op_sllv: begin
                result = rt << var_sh;
            end
            mips_alu_pkg::op_srl: begin
                result = rt >> shamt;
            end
            mips_alu_pkg::op_srlv: begin
                result = rt >> var_sh;
            end
            mips_alu_pkg::op_sra: begin
                result = $signed(rt) >>> shamt;  // sign fill
            end
            mips_alu_pkg::op_srav: begin
                result = $signed(rt) >>> var_sh;
            end
            mips_alu_pkg::op_eq: begin
                result[0] = (rs == rt);
            end
            mips_alu_pkg::op_ne: begin
                result[0] = (rs != rt);
            end
            mips_alu_pkg::op_gez: begin
                result[0] = ~rs_neg;
            end
            mips_alu_pkg::op_gtz: begin
                result[0] = ~rs_neg & ~rs_zero;
            end
            mips_alu_pkg::op_lez: begin
                result[0] = rs_neg | rs_zero;
            end
            mips_alu_pkg::op_ltz: begin
                result[0] = rs_neg;
            end
            mips_alu_pkg::op_slt: begin
                result[0] = lt_s;
            end
            mips_alu_pkg::op_sltu: begin
                result[0] = lt_u;
            end
            mips_alu_pkg::op_pass_rs: begin
                result = rs;
            end
            mips_alu_pkg::op_jump: begin
                result[0] = 1'b1;  // link constant
            end
            mips_alu_pkg::op_lui: begin
                result = rt << 16;
            end
            mips_alu_pkg::op_mult,
            mips_alu_pkg::op_multu,
            mips_alu_pkg::op_div,
            mips_alu_pkg::op_divu: begin
                result = '0;  // handled by the HI/LO unit
            end
            default: begin
                result = '0;  // illegal code
            end
        endcase
    end

endmodule

//--- design/mips_muldiv.sv
`timescale 1ns/1ps
`include "mips_alu_defs.svh"

module mips_muldiv (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  mips_alu_pkg::alu_op_t       op,
    input  logic [`MIPS_ALU_DATA_W-1:0] rs,
    input  logic [`MIPS_ALU_DATA_W-1:0] rt,
    output logic [`MIPS_ALU_DATA_W-1:0] hi,
    output logic [`MIPS_ALU_DATA_W-1:0] lo,
    output logic                        busy,
    output logic                        div_zero
);

    localparam int CNT_W = $clog2(`MIPS_ALU_DIV_STEPS) + 1;

    typedef enum logic {
        st_idle,
        st_div
    } state_t;

    state_t                       state;
    logic [CNT_W-1:0]             step_cnt;
    logic [`MIPS_ALU_DATA_W-1:0]  rem_r;     // partial remainder
    logic [`MIPS_ALU_DATA_W-1:0]  quo_r;     // dividend shifts out, quotient shifts in
    logic [`MIPS_ALU_DATA_W-1:0]  dvsr_r;
    logic                         neg_q;
    logic                         neg_r;
    logic                         is_mul;
    logic                         is_div;
    logic                         is_sdiv;
    logic [`MIPS_ALU_DATA_W-1:0]  rs_mag;
    logic [`MIPS_ALU_DATA_W-1:0]  rt_mag;
    logic [2*`MIPS_ALU_DATA_W-1:0] mul_a;
    logic [2*`MIPS_ALU_DATA_W-1:0] mul_b;
    logic [2*`MIPS_ALU_DATA_W-1:0] prod;
    logic [`MIPS_ALU_DATA_W:0]    rem_sh;
    logic [`MIPS_ALU_DATA_W:0]    rem_diff;
    logic [`MIPS_ALU_DATA_W-1:0]  quo_fix;
    logic [`MIPS_ALU_DATA_W-1:0]  rem_fix;

    assign busy = (state == st_div);

    always_comb begin
        is_mul  = (op == mips_alu_pkg::op_mult) || (op == mips_alu_pkg::op_multu);
        is_div  = (op == mips_alu_pkg::op_div) || (op == mips_alu_pkg::op_divu);
        is_sdiv = (op == mips_alu_pkg::op_div);
        rs_mag  = (is_sdiv && rs[`MIPS_ALU_DATA_W-1]) ? -rs : rs;
        rt_mag  = (is_sdiv && rt[`MIPS_ALU_DATA_W-1]) ? -rt : rt;
        // sign or zero extend, low 64 bits of the product are then exact
        if (op == mips_alu_pkg::op_mult) begin
            mul_a = {{`MIPS_ALU_DATA_W{rs[`MIPS_ALU_DATA_W-1]}}, rs};
            mul_b = {{`MIPS_ALU_DATA_W{rt[`MIPS_ALU_DATA_W-1]}}, rt};
        end else begin
            mul_a = {{`MIPS_ALU_DATA_W{1'b0}}, rs};
            mul_b = {{`MIPS_ALU_DATA_W{1'b0}}, rt};
        end
        prod     = mul_a * mul_b;
        rem_sh   = {rem_r, quo_r[`MIPS_ALU_DATA_W-1]};
        rem_diff = rem_sh - {1'b0, dvsr_r};  // msb set means restore
        quo_fix  = neg_q ? -quo_r : quo_r;
        rem_fix  = neg_r ? -rem_r : rem_r;
    end

    // control and HI/LO
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            step_cnt <= '0;
            div_zero <= 1'b0;
            hi       <= '0;
            lo       <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        div_zero <= 1'b0;
                        if (is_mul) begin
                            {hi, lo} <= prod;
                        end else if (is_div && rt == '0) begin
                            div_zero <= 1'b1;  // no iterations
                            lo       <= '1;
                            hi       <= rs;
                        end else if (is_div) begin
                            state    <= st_div;
                            step_cnt <= '0;
                        end
                    end
                end
                st_div: begin
                    if (step_cnt == CNT_W'(`MIPS_ALU_DIV_STEPS)) begin
                        hi    <= rem_fix;
                        lo    <= quo_fix;
                        state <= st_idle;
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // divider datapath
    always_ff @(posedge clk) begin
        if (state == st_idle && start && is_div) begin
            rem_r  <= '0;
            quo_r  <= rs_mag;
            dvsr_r <= rt_mag;
            neg_q  <= is_sdiv && (rs[`MIPS_ALU_DATA_W-1] ^ rt[`MIPS_ALU_DATA_W-1]);
            neg_r  <= is_sdiv && rs[`MIPS_ALU_DATA_W-1];  // remainder follows rs
        end else if (busy && step_cnt != CNT_W'(`MIPS_ALU_DIV_STEPS)) begin
            if (!rem_diff[`MIPS_ALU_DATA_W]) begin
                rem_r <= rem_diff[`MIPS_ALU_DATA_W-1:0];
                quo_r <= {quo_r[`MIPS_ALU_DATA_W-2:0], 1'b1};
            end else begin
                rem_r <= rem_sh[`MIPS_ALU_DATA_W-1:0];
                quo_r <= {quo_r[`MIPS_ALU_DATA_W-2:0], 1'b0};
            end
        end
    end

    // register block must hold off ctrl writes while dividing
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

    // load cycle plus 32 steps, then done
    a_busy_bound: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> ##[1:33] !busy);

endmodule

//--- design/mips_alu_regs.sv
`timescale 1ns/1ps
`include "mips_alu_defs.svh"

module mips_alu_regs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [`MIPS_ALU_ADR_W-1:0]   wb_adr,
    input  logic [`MIPS_ALU_DATA_W-1:0]  wb_dat_w,
    output logic [`MIPS_ALU_DATA_W-1:0]  wb_dat_r,
    output logic                         wb_ack,
    output logic [`MIPS_ALU_DATA_W-1:0]  rs,
    output logic [`MIPS_ALU_DATA_W-1:0]  rt,
    output mips_alu_pkg::alu_op_t        op,
    output logic [`MIPS_ALU_SHAMT_W-1:0] shamt,
    output logic                         start,
    input  logic [`MIPS_ALU_DATA_W-1:0]  alu_result,
    input  logic [`MIPS_ALU_DATA_W-1:0]  hi,
    input  logic [`MIPS_ALU_DATA_W-1:0]  lo,
    input  logic                         md_busy,
    input  logic                         div_zero
);

    mips_alu_pkg::reg_addr_t     addr;
    logic                        req;
    logic                        busy;
    logic                        stall;
    logic                        accept;
    logic                        wr_en;
    logic                        illegal_r;
    logic [`MIPS_ALU_DATA_W-1:0] result_r;
    logic [`MIPS_ALU_DATA_W-1:0] status;
    logic [`MIPS_ALU_DATA_W-1:0] rd_data;

    assign addr   = mips_alu_pkg::reg_addr_t'(wb_adr);
    assign req    = wb_cyc & wb_stb;
    assign busy   = start | md_busy;  // high from the ctrl ack on
    assign stall  = wb_we & busy & ((addr == mips_alu_pkg::reg_rs) ||
                                    (addr == mips_alu_pkg::reg_rt) ||
                                    (addr == mips_alu_pkg::reg_ctrl));
    assign accept = req & ~wb_ack & ~stall;  // one ack per request
    assign wr_en  = accept & wb_we;

    always_comb begin
        status = '0;
        status[`MIPS_ALU_STAT_BUSY]     = busy;
        status[`MIPS_ALU_STAT_DIV_ZERO] = div_zero;
        status[`MIPS_ALU_STAT_ILLEGAL]  = illegal_r;
    end

    // unmapped addresses read 0
    always_comb begin
        rd_data = '0;
        case (addr)
            mips_alu_pkg::reg_rs:     rd_data = rs;
            mips_alu_pkg::reg_rt:     rd_data = rt;
            mips_alu_pkg::reg_ctrl: begin
                rd_data[`MIPS_ALU_OP_W-1:0] = op;
                rd_data[`MIPS_ALU_CTRL_SHAMT_LSB +: `MIPS_ALU_SHAMT_W] = shamt;
            end
            mips_alu_pkg::reg_result: rd_data = result_r;
            mips_alu_pkg::reg_lo:     rd_data = lo;
            mips_alu_pkg::reg_hi:     rd_data = hi;
            mips_alu_pkg::reg_status: rd_data = status;
            default:                  rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            start     <= 1'b0;
            illegal_r <= 1'b0;
            rs        <= '0;
            rt        <= '0;
            op        <= mips_alu_pkg::op_add;
            shamt     <= '0;
            result_r  <= '0;
        end else begin
            wb_ack <= accept;
            start  <= wr_en && (addr == mips_alu_pkg::reg_ctrl);
            if (start) begin
                result_r <= alu_result;  // ALU settled one cycle after op update
            end
            if (wr_en) begin
                case (addr)
                    mips_alu_pkg::reg_rs: rs <= wb_dat_w;
                    mips_alu_pkg::reg_rt: rt <= wb_dat_w;
                    mips_alu_pkg::reg_ctrl: begin
                        op        <= mips_alu_pkg::alu_op_t'(wb_dat_w[`MIPS_ALU_OP_W-1:0]);
                        shamt     <= wb_dat_w[`MIPS_ALU_CTRL_SHAMT_LSB +: `MIPS_ALU_SHAMT_W];
                        illegal_r <= (wb_dat_w[`MIPS_ALU_OP_W-1:0] >= `MIPS_ALU_NUM_OPS);
                    end
                    default: begin
                    end  // writes to read-only addresses are dropped
                endcase
            end
        end
    end

    // read data goes out together with the ack
    always_ff @(posedge clk) begin
        if (accept) begin
            wb_dat_r <= rd_data;
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack);

    a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(req));

endmodule

//--- design/mips_alu_top.sv
`timescale 1ns/1ps
`include "mips_alu_defs.svh"

module mips_alu_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [`MIPS_ALU_ADR_W-1:0]  wb_adr,
    input  logic [`MIPS_ALU_DATA_W-1:0] wb_dat_w,
    output logic [`MIPS_ALU_DATA_W-1:0] wb_dat_r,
    output logic                        wb_ack
);

    logic [`MIPS_ALU_DATA_W-1:0]  rs;
    logic [`MIPS_ALU_DATA_W-1:0]  rt;
    mips_alu_pkg::alu_op_t        op;
    logic [`MIPS_ALU_SHAMT_W-1:0] shamt;
    logic                         start;
    logic [`MIPS_ALU_DATA_W-1:0]  alu_result;
    logic [`MIPS_ALU_DATA_W-1:0]  hi;
    logic [`MIPS_ALU_DATA_W-1:0]  lo;
    logic                         md_busy;
    logic                         div_zero;

    mips_alu_regs i_mips_alu_regs (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .rs         (rs),
        .rt         (rt),
        .op         (op),
        .shamt      (shamt),
        .start      (start),
        .alu_result (alu_result),
        .hi         (hi),
        .lo         (lo),
        .md_busy    (md_busy),
        .div_zero   (div_zero)
    );

    mips_alu i_mips_alu (
        .rs     (rs),
        .rt     (rt),
        .shamt  (shamt),
        .op     (op),
        .result (alu_result)
    );

    mips_muldiv i_mips_muldiv (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .op       (op),
        .rs       (rs),
        .rt       (rt),
        .hi       (hi),
        .lo       (lo),
        .busy     (md_busy),
        .div_zero (div_zero)
    );

endmodule

//--- test/mips_alu_tb.sv
`timescale 1ns/1ps
`include "mips_alu_defs.svh"

module mips_alu_tb;

    localparam int CLK_HALF = 2;

    logic                        clk;
    logic                        rst;
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    logic [`MIPS_ALU_ADR_W-1:0]  wb_adr;
    logic [`MIPS_ALU_DATA_W-1:0] wb_dat_w;
    logic [`MIPS_ALU_DATA_W-1:0] wb_dat_r;
    logic                        wb_ack;
    integer                      seed;
    int                          cycle_cnt;
    int                          wait_cycles;  // cycles the last write waited for ack

    mips_alu_top i_mips_alu_top (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial cycle_cnt = 0;
    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic wb_write(input mips_alu_pkg::reg_addr_t adr, input logic [31:0] data);
        @(negedge clk);
        wb_cyc      = 1'b1;
        wb_stb      = 1'b1;
        wb_we       = 1'b1;
        wb_adr      = adr;
        wb_dat_w    = data;
        wait_cycles = 0;
        @(negedge clk);
        while (!wb_ack) begin
            if (wait_cycles == 100) abort_run("bus write got no ack within 100 cycles");
            wait_cycles++;
            @(negedge clk);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input mips_alu_pkg::reg_addr_t adr, output logic [31:0] data);
        int n;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        n      = 0;
        @(negedge clk);
        while (!wb_ack) begin
            if (n == 100) abort_run("bus read got no ack within 100 cycles");
            n++;
            @(negedge clk);
        end
        data   = wb_dat_r;  // valid while ack is high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic poll_idle();
        logic [31:0] st;
        int          t0;
        t0 = cycle_cnt;
        wb_read(mips_alu_pkg::reg_status, st);
        while (st[`MIPS_ALU_STAT_BUSY]) begin
            if (cycle_cnt - t0 > 200) abort_run("busy did not clear within 200 cycles");
            wb_read(mips_alu_pkg::reg_status, st);
        end
    endtask

    task automatic check_word(input logic [31:0] exp, input logic [31:0] got, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_status(input logic busy_e, input logic dz_e, input logic ill_e,
                                input logic [31:0] got);
        logic [31:0] exp;
        exp = '0;
        exp[`MIPS_ALU_STAT_BUSY]     = busy_e;
        exp[`MIPS_ALU_STAT_DIV_ZERO] = dz_e;
        exp[`MIPS_ALU_STAT_ILLEGAL]  = ill_e;
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: STATUS is %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_op(input mips_alu_pkg::alu_op_t exp, input mips_alu_pkg::alu_op_t got);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: CTRL op is %0d, expected %0d", $time, got, exp));
        end
    endtask

    // loads operands and ctrl, waits for idle, reads everything back
    task automatic run_vector(input logic [4:0] code, input logic [31:0] a, input logic [31:0] b,
                              input logic [4:0] sh, input logic [31:0] e_res,
                              input logic [31:0] e_hi, input logic [31:0] e_lo,
                              input logic hilo);
        logic [31:0] rd;
        logic        is_div;
        is_div = (code == 5'd4) || (code == 5'd5);
        wb_write(mips_alu_pkg::reg_rs, a);
        wb_write(mips_alu_pkg::reg_rt, b);
        wb_write(mips_alu_pkg::reg_ctrl, (32'(sh) << `MIPS_ALU_CTRL_SHAMT_LSB) | 32'(code));
        poll_idle();
        wb_read(mips_alu_pkg::reg_status, rd);
        check_status(1'b0, is_div && (b == '0), code >= 5'd26, rd);
        wb_read(mips_alu_pkg::reg_result, rd);
        check_word(e_res, rd, $sformatf("RESULT of op %0d", code));
        if (hilo) begin
            wb_read(mips_alu_pkg::reg_lo, rd);
            check_word(e_lo, rd, $sformatf("LO of op %0d", code));
            wb_read(mips_alu_pkg::reg_hi, rd);
            check_word(e_hi, rd, $sformatf("HI of op %0d", code));
        end
        wb_read(mips_alu_pkg::reg_ctrl, rd);
        check_op(mips_alu_pkg::alu_op_t'(code), mips_alu_pkg::alu_op_t'(rd[4:0]));
        check_word(32'(sh), 32'(rd[`MIPS_ALU_CTRL_SHAMT_LSB +: 5]), "CTRL shamt");
    endtask

    task automatic run_file();
        int          fd;
        int          n;
        int          count;
        string       line;
        logic [31:0] v_op;
        logic [31:0] v_rs;
        logic [31:0] v_rt;
        logic [31:0] v_sh;
        logic [31:0] v_res;
        logic [31:0] v_hi;
        logic [31:0] v_lo;
        count = 0;
        fd    = $fopen("test/mips_alu_stimulus.txt", "r");
        if (fd == 0) abort_run("could not open test/mips_alu_stimulus.txt");
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin  // skip column notes
                n = $sscanf(line, "%h %h %h %h %h %h %h",
                            v_op, v_rs, v_rt, v_sh, v_res, v_hi, v_lo);
                if (n == 7) begin
                    run_vector(v_op[4:0], v_rs, v_rt, v_sh[4:0], v_res, v_hi, v_lo, 1'b1);
                    count++;
                end else if (n > 0) begin
                    abort_run("stimulus file has a line without seven fields");
                end
            end
        end
        $fclose(fd);
        if (count == 0) abort_run("stimulus file held no vectors");
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] a;
        logic [31:0] b;
        seed     = 10;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // every register reads 0 out of reset
        for (int i = 0; i < 6; i++) begin
            wb_read(mips_alu_pkg::reg_addr_t'(i), rd);
            check_word(32'd0, rd, $sformatf("reset value at address %0d", i));
        end
        wb_read(mips_alu_pkg::reg_ctrl, rd);
        check_op(mips_alu_pkg::op_add, mips_alu_pkg::alu_op_t'(rd[4:0]));
        wb_read(mips_alu_pkg::reg_status, rd);
        check_status(1'b0, 1'b0, 1'b0, rd);

        run_file();

        // rs write during a divide must wait for busy to fall
        a = 32'd1000;
        b = 32'd7;
        wb_write(mips_alu_pkg::reg_rs, a);
        wb_write(mips_alu_pkg::reg_rt, b);
        wb_write(mips_alu_pkg::reg_ctrl, 32'(mips_alu_pkg::op_divu));
        wb_read(mips_alu_pkg::reg_status, rd);
        check_status(1'b1, 1'b0, 1'b0, rd);
        wb_write(mips_alu_pkg::reg_rs, 32'h0000_00ff);
        if (wait_cycles < 20) abort_run("rs write was acknowledged while the divider was busy");
        wb_read(mips_alu_pkg::reg_status, rd);
        check_status(1'b0, 1'b0, 1'b0, rd);
        wb_read(mips_alu_pkg::reg_lo, rd);
        check_word(a / b, rd, "LO after held write");
        wb_read(mips_alu_pkg::reg_hi, rd);
        check_word(a % b, rd, "HI after held write");
        wb_read(mips_alu_pkg::reg_rs, rd);
        check_word(32'h0000_00ff, rd, "RS after held write");

        // RESULT is read-only and still 0 from the divu
        wb_write(mips_alu_pkg::reg_result, 32'hdead_beef);
        wb_read(mips_alu_pkg::reg_result, rd);
        check_word(32'd0, rd, "RESULT after write to read-only address");

        // illegal code clears a nonzero RESULT and keeps HI and LO of the divu
        run_vector(mips_alu_pkg::op_or, 32'h0000_00f0, 32'h0000_000f, 5'd0, 32'h0000_00ff,
                   '0, '0, 1'b0);
        run_vector(5'd27, 32'h0000_00f0, 32'h0000_000f, 5'd0, 32'd0, a % b, a / b, 1'b1);

        for (int i = 0; i < 24; i++) begin
            a = $random(seed);
            b = $random(seed);
            case (i % 3)
                0: run_vector(mips_alu_pkg::op_add, a, b, 5'd0, a + b, '0, '0, 1'b0);
                1: run_vector(mips_alu_pkg::op_xor, a, b, 5'd0, a ^ b, '0, '0, 1'b0);
                default: run_vector(mips_alu_pkg::op_sltu, a, b, 5'd0, {31'd0, a < b},
                                    '0, '0, 1'b0);
            endcase
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- test/mips_alu_stimulus.txt
# columns: op rs rt shamt result hi lo, all hex
# hi and lo carry over from the last multiply or divide
00 7fffffff 00000001 00 80000000 00000000 00000000
01 00000005 00000007 00 fffffffe 00000000 00000000
06 f0f0f0f0 ff00ff00 00 f000f000 00000000 00000000
07 f0f0f0f0 0f0f0000 00 fffff0f0 00000000 00000000
08 aaaaaaaa ffff0000 00 5555aaaa 00000000 00000000
09 00000000 00000003 04 00000030 00000000 00000000
0a 00000024 80000001 00 00000010 00000000 00000000
0b 00000000 80000000 1f 00000001 00000000 00000000
0c 00000008 f0000000 00 00f00000 00000000 00000000
0d 00000000 80000000 04 f8000000 00000000 00000000
0e 0000001f 80000000 00 ffffffff 00000000 00000000
0f 12345678 12345678 00 00000001 00000000 00000000
16 12345678 12345678 00 00000000 00000000 00000000
10 ffffffff 00000000 00 00000000 00000000 00000000
11 00000000 00000000 00 00000000 00000000 00000000
12 00000000 00000000 00 00000001 00000000 00000000
13 80000000 00000000 00 00000001 00000000 00000000
14 ffffffff 00000001 00 00000001 00000000 00000000
15 ffffffff 00000001 00 00000000 00000000 00000000
17 cafef00d 00000000 00 cafef00d 00000000 00000000
18 00000000 00000000 00 00000001 00000000 00000000
19 00000000 00001234 00 12340000 00000000 00000000
02 80000000 80000000 00 00000000 40000000 00000000
03 ffffffff ffffffff 00 00000000 fffffffe 00000001
02 ffffffff 00000002 00 00000000 ffffffff fffffffe
04 fffffff9 00000002 00 00000000 ffffffff fffffffd
05 fffffff9 00000002 00 00000000 00000001 7ffffffc
04 00000064 fffffff9 00 00000000 00000002 fffffff2
04 00001234 00000000 00 00000000 00001234 ffffffff
05 00000010 00000000 00 00000000 00000010 ffffffff
1b 11111111 22222222 00 00000000 00000010 ffffffff

//--- mips_alu_top.f
+incdir+include
design/mips_alu_pkg.sv
design/mips_alu.sv
design/mips_muldiv.sv
design/mips_alu_regs.sv
design/mips_alu_top.sv
test/mips_alu_tb.sv

//--- Makefile
VERILATOR ?= verilator

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f mips_alu_top.f \
		--top-module mips_alu_tb --Mdir obj_dir -o mips_alu_tb
	./obj_dir/mips_alu_tb

clean:
	rm -rf obj_dir
